// File: project.f
+incdir+logic
logic/vector_pkg.sv
logic/vector_apb_regs.sv
logic/display_list.sv
logic/vector_sequencer.sv
logic/line_rasterizer.sv
logic/frame_buffer.sv
logic/vector_engine_top.sv
verification/vector_engine_props.sv
verification/vector_engine_tb.sv

// File: Bender.yml
package:
  name: vector_engine

sources:
  - include_dirs:
      - logic
    files:
      - logic/vector_pkg.sv
      - logic/vector_apb_regs.sv
      - logic/display_list.sv
      - logic/vector_sequencer.sv
      - logic/line_rasterizer.sv
      - logic/frame_buffer.sv
      - logic/vector_engine_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verification/vector_engine_props.sv
      - verification/vector_engine_tb.sv

// File: verification/vector_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module vector_engine_tb
    import vector_pkg::*;
();

    localparam int APB_LIMIT  = 16;
    localparam int POLL_LIMIT = 6000;
    localparam int NPTS       = 16;

    logic        clk;
    logic        i_rst_n;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [15:0] i_paddr;
    logic [31:0] i_pwdata;
    logic [31:0] o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        o_done_irq;

    bit          model [64][64];
    logic [13:0] cmd_q [$];
    logic [31:0] lcg_state;
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          test_mark;

    vector_engine_top uut (
        .clk(clk), .i_rst_n(i_rst_n), .i_psel(i_psel), .i_penable(i_penable),
        .i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_done_irq(o_done_irq)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [15:0] addr,
                               input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            error_count++;
            $display("error: %s at address %h expected %h actual %h", name, addr, exp, got);
        end
    endtask

    // Setup phase then access phase until PREADY
    task automatic apb_xfer(input logic write, input logic [15:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        #1;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(posedge clk);
        #1;
        i_penable = 1'b1;
        @(negedge clk);
        while (o_pready !== 1'b1 && waits < APB_LIMIT) begin
            @(negedge clk);
            waits++;
        end
        if (o_pready !== 1'b1) begin
            abort_run("PREADY never came high in the access phase");
        end
        rdata = o_prdata;
        err   = o_pslverr;
        @(posedge clk);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value("o_pslverr", addr, {31'd0, exp_err}, {31'd0, err});
    endtask

    task automatic apb_read(input logic [15:0] addr, input logic exp_err,
                            output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        check_value("o_pslverr", addr, {31'd0, exp_err}, {31'd0, err});
    endtask

    task automatic wait_status(input int bit_idx, input logic level, input string what);
        logic [31:0] st;
        int          polls;
        polls = 0;
        apb_read(`VEC_REG_STATUS, 1'b0, st);
        while (st[bit_idx] !== level && polls < POLL_LIMIT) begin
            apb_read(`VEC_REG_STATUS, 1'b0, st);
            polls++;
        end
        if (st[bit_idx] !== level) begin
            abort_run(what);
        end
    endtask

    function automatic int rand_coord();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[27:22]);
    endfunction

    // Integer Bresenham over all octants including the endpoint
    function automatic void line_model(input int x0, input int y0, input int x1, input int y1);
        int dx;
        int dy;
        int sx;
        int sy;
        int err;
        int e2;
        int x;
        int y;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
        sx  = (x1 >= x0) ? 1 : -1;
        sy  = (y1 >= y0) ? 1 : -1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        while (1) begin
            model[x][y] = 1'b1;
            if (x == x1 && y == y1) begin
                break;
            end
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endfunction

    // Pen starts at the origin for every run
    function automatic void apply_model();
        vec_op_t op;
        int      px;
        int      py;
        int      cx;
        int      cy;
        px = 0;
        py = 0;
        foreach (cmd_q[i]) begin
            op = vec_op_t'(cmd_q[i][13:12]);
            cx = int'(cmd_q[i][11:6]);
            cy = int'(cmd_q[i][5:0]);
            if (op == OP_END) begin
                break;
            end
            if (op == OP_POS) begin
                line_model(cx, cy, cx, cy);
            end else if (op == OP_LINE) begin
                line_model(px, py, cx, cy);
            end
            if (op != OP_NOP) begin
                px = cx;
                py = cy;
            end
        end
    endfunction

    task automatic add_cmd(input vec_op_t op, input int x, input int y);
        logic [13:0] entry;
        entry = {op, 6'(x), 6'(y)};
        apb_write(`VEC_LIST_BASE + 16'(4 * cmd_q.size()), {18'd0, entry}, 1'b0);
        cmd_q.push_back(entry);
    endtask

    task automatic run_list();
        apb_write(`VEC_REG_CTRL, 32'h1, 1'b0);
        wait_status(2, 1'b1, "done bit did not rise after RUN");
        check_value("o_done_irq", `VEC_REG_STATUS, 32'd1, {31'd0, o_done_irq});
        apply_model();
    endtask

    // Done is sticky, so only the running and clearing bits are compared
    task automatic clear_frame();
        logic [31:0] st;
        apb_write(`VEC_REG_CTRL, 32'h2, 1'b0);
        apb_read(`VEC_REG_STATUS, 1'b0, st);
        check_value("o_prdata[1:0]", `VEC_REG_STATUS, 32'h2, {30'd0, st[1:0]});
        wait_status(1, 1'b0, "clearing bit did not fall after CLEAR");
        foreach (model[i, j]) begin
            model[i][j] = 1'b0;
        end
    endtask

    task automatic check_window(input int x0, input int y0, input int x1, input int y1);
        logic [31:0] rd;
        logic [15:0] addr;
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                addr = `VEC_FB_BASE + 16'(4 * (y * 64 + x));
                apb_read(addr, 1'b0, rd);
                check_value("o_prdata", addr, {31'd0, model[x][y]}, rd);
            end
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - test_mark;
        test_count++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, errs);
        end
        test_mark = error_count;
    endtask

    initial begin
        logic [31:0] rd;
        vec_op_t     op;
        int          cx [NPTS];
        int          cy [NPTS];
        int          prop_fails;
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        lcg_state    = 32'he00c_90e7;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        test_mark    = 0;
        repeat (10) @(posedge clk);
        #1;
        i_rst_n = 1'b1;

        apb_read(`VEC_REG_STATUS, 1'b0, rd);
        check_value("o_prdata", `VEC_REG_STATUS, 32'd0, rd);
        apb_read(16'h0008, 1'b1, rd);
        apb_read(16'h0180, 1'b1, rd);
        apb_write(16'h0008, 32'h1, 1'b1);
        apb_read(`VEC_REG_STATUS, 1'b0, rd);
        check_value("o_prdata", `VEC_REG_STATUS, 32'd0, rd);
        clear_frame();
        apb_write(`VEC_FB_BASE, 32'h1, 1'b1);
        apb_read(`VEC_FB_BASE, 1'b0, rd);
        check_value("o_prdata", `VEC_FB_BASE, 32'd0, rd);
        finish_test("reset status and bus errors");

        cmd_q.delete();
        add_cmd(OP_POS, 10, 20);
        add_cmd(OP_END, 0, 0);
        run_list();
        check_window(7, 17, 13, 23);
        finish_test("single dot");

        cmd_q.delete();
        add_cmd(OP_POS, 5, 10);
        add_cmd(OP_LINE, 40, 10);
        add_cmd(OP_LINE, 40, 50);
        add_cmd(OP_END, 0, 0);
        run_list();
        check_window(0, 9, 63, 11);
        check_window(39, 8, 41, 52);
        finish_test("horizontal and vertical lines");

        // Two chains of eight points each
        for (int i = 0; i < NPTS; i++) begin
            cx[i] = rand_coord();
            cy[i] = rand_coord();
        end
        // First dot must differ from where the pen rests before this run and a rerun
        while ((cx[0] == 40 && cy[0] == 50) || (cx[0] == cx[NPTS-1] && cy[0] == cy[NPTS-1])) begin
            cx[0] = (cx[0] + 1) % 64;
        end
        cmd_q.delete();
        for (int i = 0; i < NPTS; i++) begin
            if (i % 8 == 0) begin
                op = OP_POS;
            end else begin
                op = OP_LINE;
            end
            add_cmd(op, cx[i], cy[i]);
        end
        add_cmd(OP_END, 0, 0);
        run_list();
        check_window(0, 0, 63, 63);
        finish_test("random line chains");

        clear_frame();
        check_window(0, 0, 63, 63);
        finish_test("frame clear");

        run_list();
        check_window(0, 0, 63, 63);
        finish_test("rerun from entry zero");

        prop_fails = uut.u_seq.u_seq_props.fail_count + uut.u_rast.u_rast_props.fail_count;
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 test_count, failed_tests, error_count, prop_fails);
        if (error_count == 0 && prop_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/vector_engine_props.sv
`timescale 1ns/1ps
`default_nettype none

module vector_engine_props (
    input wire logic clk,
    input wire logic i_rst_n,
    input wire logic i_go,
    input wire logic i_busy,
    input wire logic i_list_inc,
    input wire logic i_list_zero
);

    int fail_count = 0;

    // Sequencer must not start a segment over a running one
    go_not_busy: assert property (@(posedge clk) disable iff (!i_rst_n) i_go |-> !i_busy)
        else begin
            fail_count++;
            $error("go raised while the rasterizer was busy");
        end

    // Rasterizer picks up a segment on the edge after go
    go_then_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_go |=> i_busy)
        else begin
            fail_count++;
            $error("busy did not rise on the edge after go");
        end

    inc_zero_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_list_inc && i_list_zero))
        else begin
            fail_count++;
            $error("list increment and list zero raised together");
        end

    // First cycle out of reset
    reset_values: assert property (@(posedge clk)
        $rose(i_rst_n) |-> !i_go && !i_busy && !i_list_inc)
        else begin
            fail_count++;
            $error("go, busy or list increment high right after reset");
        end

endmodule

bind vector_sequencer vector_engine_props u_seq_props (
    .clk(clk), .i_rst_n(i_rst_n), .i_go(o_go), .i_busy(i_busy),
    .i_list_inc(o_list_inc), .i_list_zero(o_list_zero)
);

bind line_rasterizer vector_engine_props u_rast_props (
    .clk(clk), .i_rst_n(i_rst_n), .i_go(i_go), .i_busy(o_busy),
    .i_list_inc(1'b0), .i_list_zero(1'b0)
);

`default_nettype wire

// File: logic/vector_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module vector_engine_top
    import vector_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [`VEC_APB_AW-1:0] i_paddr,
    input  logic [31:0]            i_pwdata,
    output logic [31:0]            o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    output logic                   o_done_irq
);

    logic        run_start;
    logic        clear_start;
    logic        list_we;
    list_addr_t  list_waddr;
    list_entry_t list_wdata;
    pixel_t      fb_raddr;
    logic        fb_rdata;
    logic        running;
    logic        clearing;
    logic        done;
    list_entry_t cmd;
    logic        list_zero;
    logic        list_inc;
    logic        go;
    segment_t    seg;
    logic        busy;
    pixel_t      cur;
    logic        plot_valid;
    pixel_t      plot_pix;

    vector_apb_regs u_regs (
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_run_start(run_start), .o_clear_start(clear_start),
        .o_list_we(list_we), .o_list_waddr(list_waddr), .o_list_wdata(list_wdata),
        .o_fb_raddr(fb_raddr), .i_fb_rdata(fb_rdata),
        .i_running(running), .i_clearing(clearing), .i_done(done)
    );

    display_list u_list (
        .clk(clk), .i_rst_n(i_rst_n), .i_we(list_we), .i_waddr(list_waddr),
        .i_wdata(list_wdata), .i_zero(list_zero), .i_inc(list_inc), .o_cmd(cmd)
    );

    vector_sequencer u_seq (
        .clk(clk), .i_rst_n(i_rst_n), .i_run_start(run_start), .i_cmd(cmd),
        .i_busy(busy), .i_cur(cur), .o_go(go), .o_seg(seg),
        .o_list_zero(list_zero), .o_list_inc(list_inc),
        .o_running(running), .o_done(done)
    );

    line_rasterizer u_rast (
        .clk(clk), .i_rst_n(i_rst_n), .i_go(go), .i_seg(seg), .o_busy(busy),
        .o_cur(cur), .o_plot_valid(plot_valid), .o_plot_pix(plot_pix)
    );

    frame_buffer u_fb (
        .clk(clk), .i_rst_n(i_rst_n), .i_plot_valid(plot_valid),
        .i_plot_pix(plot_pix), .i_clear_start(clear_start), .i_raddr(fb_raddr),
        .o_rdata(fb_rdata), .o_clearing(clearing)
    );

    assign o_done_irq = done;

endmodule

`default_nettype wire

// File: logic/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module frame_buffer
    import vector_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_plot_valid,
    input  pixel_t i_plot_pix,
    input  logic   i_clear_start,
    input  pixel_t i_raddr,
    output logic   o_rdata,
    output logic   o_clearing
);

    localparam int NPIX  = (`VEC_FRAME_MAX + 1) * (`VEC_FRAME_MAX + 1);
    localparam int IDX_W = $clog2(NPIX);

    logic [NPIX-1:0]  bitmap;
    clear_state_t     state;
    logic [IDX_W-1:0] clr_idx;
    logic [IDX_W-1:0] plot_idx;
    logic [IDX_W-1:0] rd_idx;

    // Row-major, y * 64 + x
    assign plot_idx = {i_plot_pix.y, i_plot_pix.x};
    assign rd_idx   = {i_raddr.y, i_raddr.x};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state   <= CLR_IDLE;
            clr_idx <= '0;
        end else if (state == CLR_IDLE) begin
            if (i_clear_start) begin
                state   <= CLR_SWEEP;
                clr_idx <= '0;
            end
        end else begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == IDX_W'(NPIX - 1)) begin
                state <= CLR_IDLE;
            end
        end
    end

    // Sweep write comes last so it wins on the same bit
    always_ff @(posedge clk) begin
        if (i_plot_valid) begin
            bitmap[plot_idx] <= 1'b1;
        end
        if (state == CLR_SWEEP) begin
            bitmap[clr_idx] <= 1'b0;
        end
    end

    assign o_rdata    = bitmap[rd_idx];
    assign o_clearing = (state == CLR_SWEEP);

endmodule

`default_nettype wire

// File: logic/line_rasterizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module line_rasterizer
    import vector_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_go,
    input  segment_t i_seg,
    output logic     o_busy,
    output pixel_t   o_cur,
    output logic     o_plot_valid,
    output pixel_t   o_plot_pix
);

    // Room for twice the largest delta plus sign
    localparam int ERR_W = `VEC_COORD_W + 3;

    raster_state_t           state;
    coord_t                  x;
    coord_t                  y;
    coord_t                  end_x;
    coord_t                  end_y;
    coord_t                  x_step;
    coord_t                  y_step;
    logic                    x_neg;
    logic                    y_neg;
    logic                    at_end;
    logic signed [ERR_W-1:0] diff_x;
    logic signed [ERR_W-1:0] diff_y;
    logic signed [ERR_W-1:0] abs_dx;
    logic signed [ERR_W-1:0] neg_ady;
    logic signed [ERR_W-1:0] dx;
    logic signed [ERR_W-1:0] dy;
    logic signed [ERR_W-1:0] err;
    logic signed [ERR_W-1:0] e2;
    logic signed [ERR_W-1:0] err_step;

    // Segment setup
    assign diff_x  = ERR_W'(i_seg.end_x) - ERR_W'(i_seg.start_x);
    assign diff_y  = ERR_W'(i_seg.end_y) - ERR_W'(i_seg.start_y);
    assign abs_dx  = diff_x[ERR_W-1] ? -diff_x : diff_x;
    assign neg_ady = diff_y[ERR_W-1] ? diff_y : -diff_y;

    assign at_end = (x == end_x) && (y == end_y);
    assign e2     = err <<< 1;

    always_comb begin
        err_step = err;
        x_step   = x;
        y_step   = y;
        if (e2 >= dy) begin
            err_step = err_step + dy;
            x_step   = x_neg ? x - 1'b1 : x + 1'b1;
        end
        if (e2 <= dx) begin
            err_step = err_step + dx;
            y_step   = y_neg ? y - 1'b1 : y + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_go) begin
                        state <= STEP;
                        x     <= i_seg.start_x;
                        y     <= i_seg.start_y;
                    end
                end
                STEP: begin
                    if (at_end) begin
                        state <= IDLE;
                    end else begin
                        x <= x_step;
                        y <= y_step;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && i_go) begin
            end_x <= i_seg.end_x;
            end_y <= i_seg.end_y;
            x_neg <= diff_x[ERR_W-1];
            y_neg <= diff_y[ERR_W-1];
            dx    <= abs_dx;
            dy    <= neg_ady;
            err   <= abs_dx + neg_ady;
        end else if (state == STEP && !at_end) begin
            err <= err_step;
        end
    end

    assign o_busy       = (state == STEP);
    assign o_plot_valid = (state == STEP);
    assign o_cur        = '{x: x, y: y};
    assign o_plot_pix   = '{x: x, y: y};

endmodule

`default_nettype wire

// File: logic/vector_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module vector_sequencer
    import vector_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_run_start,
    input  list_entry_t i_cmd,
    input  logic        i_busy,
    input  pixel_t      i_cur,
    output logic        o_go,
    output segment_t    o_seg,
    output logic        o_list_zero,
    output logic        o_list_inc,
    output logic        o_running,
    output logic        o_done
);

    localparam int DWELL_W = $clog2(`VEC_DWELL + 1);

    pixel_t             pen;
    pixel_t             pen_nxt;
    pixel_t             target;
    segment_t           seg_nxt;
    logic               go_nxt;
    logic               zero_nxt;
    logic               inc_nxt;
    logic               running_nxt;
    logic               done_nxt;
    logic [DWELL_W-1:0] dwell;
    logic [DWELL_W-1:0] dwell_nxt;
    logic               at_target;

    assign target.x  = i_cmd.x;
    assign target.y  = i_cmd.y;
    assign at_target = (i_cur == target);

    always_comb begin
        go_nxt      = 1'b0;
        zero_nxt    = 1'b0;
        inc_nxt     = 1'b0;
        dwell_nxt   = '0;
        seg_nxt     = o_seg;
        pen_nxt     = pen;
        running_nxt = o_running;
        done_nxt    = o_done;

        if (i_run_start) begin
            running_nxt = 1'b1;
            done_nxt    = 1'b0;
        end else if (o_running) begin
            if (i_cmd.op == OP_END) begin
                // Rewind the list and park the pen at the origin
                zero_nxt    = 1'b1;
                running_nxt = 1'b0;
                done_nxt    = 1'b1;
                pen_nxt     = '0;
            end else if (at_target) begin
                // Rest on the target, then step the list
                if (!o_list_inc) begin
                    if (dwell == DWELL_W'(`VEC_DWELL)) begin
                        inc_nxt = 1'b1;
                    end else begin
                        dwell_nxt = dwell + 1'b1;
                    end
                end
            end else if (!i_busy && !o_go) begin
                case (i_cmd.op)
                    OP_POS: begin
                        go_nxt  = 1'b1;
                        seg_nxt = '{start_x: target.x, start_y: target.y,
                                    end_x: target.x, end_y: target.y};
                        pen_nxt = target;
                    end
                    OP_LINE: begin
                        go_nxt  = 1'b1;
                        seg_nxt = '{start_x: pen.x, start_y: pen.y,
                                    end_x: target.x, end_y: target.y};
                        pen_nxt = target;
                    end
                    default: begin
                        // NOP waits for the pen
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pen         <= '0;
            o_go        <= 1'b0;
            o_list_zero <= 1'b1;
            o_list_inc  <= 1'b0;
            o_running   <= 1'b0;
            o_done      <= 1'b0;
            dwell       <= '0;
        end else begin
            pen         <= pen_nxt;
            o_go        <= go_nxt;
            o_list_zero <= zero_nxt;
            o_list_inc  <= inc_nxt;
            o_running   <= running_nxt;
            o_done      <= done_nxt;
            dwell       <= dwell_nxt;
        end
    end

    always_ff @(posedge clk) begin
        o_seg <= seg_nxt;
    end

endmodule

`default_nettype wire

// File: logic/display_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module display_list
    import vector_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_we,
    input  list_addr_t  i_waddr,
    input  list_entry_t i_wdata,
    input  logic        i_zero,
    input  logic        i_inc,
    output list_entry_t o_cmd
);

    list_entry_t mem [`VEC_LIST_DEPTH];
    list_addr_t  rd_ptr;

    // Host write port
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Read pointer, wraps naturally at the list depth
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
        end else if (i_zero) begin
            rd_ptr <= '0;
        end else if (i_inc) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign o_cmd = mem[rd_ptr];

endmodule

`default_nettype wire

// File: logic/vector_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module vector_apb_regs
    import vector_pkg::*;
(
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [`VEC_APB_AW-1:0] i_paddr,
    input  logic [31:0]            i_pwdata,
    output logic [31:0]            o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,

    output logic                   o_run_start,
    output logic                   o_clear_start,
    output logic                   o_list_we,
    output list_addr_t             o_list_waddr,
    output list_entry_t            o_list_wdata,
    output pixel_t                 o_fb_raddr,

    input  logic                   i_fb_rdata,
    input  logic                   i_running,
    input  logic                   i_clearing,
    input  logic                   i_done
);

    localparam int AW       = `VEC_APB_AW;
    localparam int LIST_END = `VEC_LIST_BASE + 4 * `VEC_LIST_DEPTH;
    localparam int FB_END   = `VEC_FB_BASE + (4 << (2 * `VEC_COORD_W));

    logic          access;
    logic          aligned;
    logic          hit_ctrl;
    logic          hit_status;
    logic          hit_list;
    logic          hit_fb;
    logic          mapped;
    logic [AW-1:0] list_off;
    logic [AW-1:0] fb_off;

    assign access  = i_psel & i_penable;
    assign aligned = (i_paddr[1:0] == 2'b00);

    // Address decode
    assign hit_ctrl   = aligned && (i_paddr == `VEC_REG_CTRL);
    assign hit_status = aligned && (i_paddr == `VEC_REG_STATUS);
    assign hit_list   = aligned && (i_paddr >= `VEC_LIST_BASE) && (i_paddr < LIST_END);
    assign hit_fb     = aligned && (i_paddr >= `VEC_FB_BASE) && (i_paddr < FB_END);
    assign mapped     = hit_ctrl | hit_status | hit_list | hit_fb;

    assign list_off = i_paddr - `VEC_LIST_BASE;
    assign fb_off   = i_paddr - `VEC_FB_BASE;

    // No wait states
    assign o_pready  = 1'b1;
    assign o_pslverr = access & (~mapped | (i_pwrite & hit_fb));

    // Write-one-to-start control bits
    assign o_run_start   = access & i_pwrite & hit_ctrl & i_pwdata[0];
    assign o_clear_start = access & i_pwrite & hit_ctrl & i_pwdata[1];

    assign o_list_we    = access & i_pwrite & hit_list;
    assign o_list_waddr = list_off[2 +: `VEC_LIST_AW];
    assign o_list_wdata = i_pwdata[$bits(list_entry_t)-1:0];

    // Pixel index is y * 64 + x, one word per pixel
    assign o_fb_raddr.x = fb_off[2 +: `VEC_COORD_W];
    assign o_fb_raddr.y = fb_off[2 + `VEC_COORD_W +: `VEC_COORD_W];

    always_comb begin
        o_prdata = 32'd0;
        if (hit_status) begin
            o_prdata = {29'd0, i_done, i_clearing, i_running};
        end else if (hit_fb) begin
            o_prdata = {31'd0, i_fb_rdata};
        end
    end

endmodule

`default_nettype wire

// File: logic/vector_pkg.sv
`default_nettype none

`include "vector_cfg.svh"

package vector_pkg;

    typedef logic [`VEC_COORD_W-1:0] coord_t;
    typedef logic [`VEC_LIST_AW-1:0] list_addr_t;

    typedef enum logic [1:0] {
        OP_NOP  = 2'd0,
        OP_POS  = 2'd1,
        OP_LINE = 2'd2,
        OP_END  = 2'd3
    } vec_op_t;

    // Bits 13:12 opcode, 11:6 x, 5:0 y
    typedef struct packed {
        vec_op_t op;
        coord_t  x;
        coord_t  y;
    } list_entry_t;

    typedef struct packed {
        coord_t start_x;
        coord_t start_y;
        coord_t end_x;
        coord_t end_y;
    } segment_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_t;

    typedef enum logic {IDLE, STEP} raster_state_t;
    typedef enum logic {CLR_IDLE, CLR_SWEEP} clear_state_t;

endpackage

`default_nettype wire

// File: logic/vector_cfg.svh
`ifndef VECTOR_CFG_SVH
`define VECTOR_CFG_SVH

// Frame geometry
`define VEC_COORD_W     6
`define VEC_FRAME_MAX   63

// Display list
`define VEC_LIST_DEPTH  32
`define VEC_LIST_AW     5

// Pen rest time on a target before the list advances
`define VEC_DWELL       4

// APB map
`define VEC_APB_AW      16
`define VEC_REG_CTRL    16'h0000
`define VEC_REG_STATUS  16'h0004
`define VEC_LIST_BASE   16'h0100
`define VEC_FB_BASE     16'h8000

`endif
